/* capture_pkg.sv */
`default_nettype none

package capture_pkg;

  // defaults picked up by the top level
  parameter int unsigned DEFAULT_DDS_LATENCY = 2;   // dac waveform latency, cycles
  parameter int unsigned DEFAULT_FIFO_DEPTH  = 64;  // frame words
  parameter int unsigned CNT_W               = 32;  // sample and global counters

  // route fields inside the 32-bit control word
  parameter int unsigned ROUTE_SEL_W     = 2;
  parameter int unsigned ROUTE_LOWER_LSB = 0;  // bits 1:0
  parameter int unsigned ROUTE_UPPER_LSB = 4;  // bits 5:4

  // one adc or dac sample, i in the upper half
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_sample_t;

  // source of one 32-bit half of a data word
  typedef enum logic [ROUTE_SEL_W-1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_SAMPLE_CNT = 2'd2,
    ROUTE_GLOBAL_CNT = 2'd3
  } route_sel_e;

  typedef struct packed {
    route_sel_e route_upper;  // from control word 5:4
    route_sel_e route_lower;  // from control word 1:0
  } route_ctrl_t;

  // word as it is written into the fifo
  typedef struct packed {
    logic [63:0] data;
    logic        last;   // trailer only
  } frame_word_t;

  // frame markers from the capture control
  typedef struct packed {
    logic active;  // level, synchronized enable
    logic first;   // one cycle, header slot
    logic last;    // one cycle, trailer slot
  } frame_mark_t;

endpackage

`default_nettype wire

/* capture_ctrl.sv */
`default_nettype none

module capture_ctrl #(
  parameter int unsigned DDS_LATENCY = capture_pkg::DEFAULT_DDS_LATENCY
) (
  input  wire logic                     clk_245_76MHz,
  input  wire logic                     cpu_reset,
  input  wire logic                     adc_enable_i,
  input  wire logic                     chirp_init_i,
  output capture_pkg::frame_mark_t      mark_o
);

  // wide enough to hold the latency, never zero width
  localparam int unsigned LAT_W = (DDS_LATENCY > 0) ? $clog2(DDS_LATENCY + 1) : 1;

  logic             enable_r;    // first sync stage
  logic             enable_rr;   // second stage, frame level
  logic [LAT_W-1:0] hold_cnt;    // hold-off while dac latency drains
  logic             hold_zero;
  logic             first_r;
  logic             last_w;

  assign hold_zero = (hold_cnt == '0);

  // enable synchronizer
  // the second stage only follows once the hold-off has run out
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r  <= 1'b0;
      enable_rr <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
      if (hold_zero) begin
        enable_rr <= enable_r;
      end
    end
  end

  // reload on chirp init or a falling enable, then count down
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      hold_cnt <= '0;
    end else if (chirp_init_i) begin
      hold_cnt <= LAT_W'(DDS_LATENCY);
    end else if (enable_r && !adc_enable_i) begin
      hold_cnt <= LAT_W'(DDS_LATENCY);  // enable just dropped
    end else if (!hold_zero) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // header pulse lands on the first cycle that active is high
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_r <= 1'b0;
    end else begin
      first_r <= hold_zero && enable_r && !enable_rr;
    end
  end

  // trailer slot is the last active cycle
  assign last_w = hold_zero && enable_rr && !enable_r;

  always_comb begin
    mark_o.active = enable_rr;
    mark_o.first  = first_r;
    mark_o.last   = last_w;
  end

endmodule

`default_nettype wire

/* frame_assembler.sv */
`default_nettype none

module frame_assembler (
  input  wire logic                     clk_245_76MHz,
  input  wire logic                     cpu_reset,
  input  capture_pkg::frame_mark_t      mark_i,
  input  capture_pkg::iq_sample_t       adc_iq_i,
  input  capture_pkg::iq_sample_t       dac_iq_i,
  input  wire logic                     adc_valid_i,
  input  wire logic [31:0]              control_word_i,
  output logic                          wr_o,
  output capture_pkg::frame_word_t      word_o
);

  import capture_pkg::*;

  logic [CNT_W-1:0] sample_cnt;   // data words written
  logic [CNT_W-1:0] glbl_cnt;     // free running cycle count
  route_ctrl_t      route_q;
  logic             marker;       // header or trailer slot
  logic             data_wr;
  logic [31:0]      upper_w;
  logic [31:0]      lower_w;

  // pick one 32-bit source for a half word
  function automatic logic [31:0] route_mux(
    input route_sel_e  sel,
    input logic [31:0] adc,
    input logic [31:0] dac,
    input logic [31:0] scnt,
    input logic [31:0] gcnt
  );
    logic [31:0] res;
    case (sel)
      ROUTE_ADC_IQ:     res = adc;
      ROUTE_DAC_IQ:     res = dac;
      ROUTE_SAMPLE_CNT: res = scnt;
      default:          res = gcnt;  // global counter
    endcase
    return res;
  endfunction

  // selectors take effect one cycle after the control word
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_q <= '{route_upper: ROUTE_ADC_IQ, route_lower: ROUTE_ADC_IQ};
    end else begin
      route_q.route_lower <= route_sel_e'(control_word_i[ROUTE_LOWER_LSB +: ROUTE_SEL_W]);
      route_q.route_upper <= route_sel_e'(control_word_i[ROUTE_UPPER_LSB +: ROUTE_SEL_W]);
    end
  end

  assign marker  = mark_i.first | mark_i.last;
  assign data_wr = mark_i.active & adc_valid_i & ~marker;  // markers take the slot

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
      glbl_cnt   <= '0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
      if (data_wr) begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  assign upper_w = route_mux(route_q.route_upper, adc_iq_i, dac_iq_i,
                             32'(sample_cnt), 32'(glbl_cnt));
  assign lower_w = route_mux(route_q.route_lower, adc_iq_i, dac_iq_i,
                             32'(sample_cnt), 32'(glbl_cnt));

  // header and trailer carry {global, samples} before this cycle's increment
  always_comb begin
    wr_o        = data_wr | marker;
    word_o.last = mark_i.last;
    if (marker) begin
      word_o.data = {32'(glbl_cnt), 32'(sample_cnt)};
    end else begin
      word_o.data = {upper_w, lower_w};
    end
  end

endmodule

`default_nettype wire

/* sample_fifo.sv */
`default_nettype none

module sample_fifo #(
  parameter int unsigned DEPTH = capture_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire logic                     clk_245_76MHz,
  input  wire logic                     cpu_reset,
  input  wire logic                     wr_i,
  input  capture_pkg::frame_word_t      word_i,
  input  wire logic                     pop_i,
  output capture_pkg::frame_word_t      word_o,
  output logic                          empty_o,
  output logic                          overflow_o
);

  import capture_pkg::*;

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  frame_word_t   mem [DEPTH];   // no reset on storage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;          // words held
  logic          full;
  logic          do_wr;
  logic          do_rd;

  // circular increment, depth need not be a power of two
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (fill == (AW+1)'(DEPTH));
  assign empty_o = (fill == '0);
  assign do_wr   = wr_i & ~full;     // write when full is lost
  assign do_rd   = pop_i & ~empty_o;

  always_ff @(posedge clk_245_76MHz) begin
    if (do_wr) begin
      mem[wr_ptr] <= word_i;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= ptr_next(wr_ptr);
      if (do_rd) rd_ptr <= ptr_next(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // both or neither
      endcase
      if (wr_i && full) begin
        overflow_o <= 1'b1;  // sticky until reset
      end
    end
  end

  assign word_o = mem[rd_ptr];  // head word

endmodule

`default_nettype wire

/* stream_out.sv */
`default_nettype none

module stream_out (
  input  wire logic                     clk_245_76MHz,
  input  wire logic                     cpu_reset,
  input  capture_pkg::frame_word_t      word_i,
  input  wire logic                     empty_i,
  output logic                          pop_o,
  output logic                          m_valid_o,
  output logic [63:0]                   m_data_o,
  output logic                          m_last_o,
  input  wire logic                     m_ready_i
);

  logic valid_q;
  logic [63:0] data_q;
  logic last_q;

  // refill when the register is free or its word leaves this cycle
  assign pop_o = ~empty_i & (~valid_q | m_ready_i);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      valid_q <= 1'b0;
    end else if (pop_o) begin
      valid_q <= 1'b1;
    end else if (m_ready_i) begin
      valid_q <= 1'b0;  // accepted, nothing behind it
    end
  end

  // payload only moves on a pop, held under back-pressure
  always_ff @(posedge clk_245_76MHz) begin
    if (pop_o) begin
      data_q <= word_i.data;
      last_q <= word_i.last;
    end
  end

  assign m_valid_o = valid_q;
  assign m_data_o  = data_q;
  assign m_last_o  = last_q;

endmodule

`default_nettype wire

/* adc_capture_top.sv */
`default_nettype none

module adc_capture_top #(
  parameter int unsigned DDS_LATENCY = capture_pkg::DEFAULT_DDS_LATENCY,
  parameter int unsigned FIFO_DEPTH  = capture_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire logic                     clk_245_76MHz,
  input  wire logic                     cpu_reset,
  input  wire logic                     adc_enable_i,
  input  wire logic                     chirp_init_i,
  input  capture_pkg::iq_sample_t       adc_iq_i,
  input  capture_pkg::iq_sample_t       dac_iq_i,
  input  wire logic                     adc_valid_i,
  input  wire logic [31:0]              control_word_i,
  output logic                          m_valid_o,
  output logic [63:0]                   m_data_o,
  output logic                          m_last_o,
  input  wire logic                     m_ready_i,
  output logic                          overflow_o
);

  import capture_pkg::*;

  frame_mark_t mark;
  frame_word_t wr_word;   // assembler to fifo
  frame_word_t head_word; // fifo head to output stage
  logic        wr;
  logic        fifo_empty;
  logic        pop;

  capture_ctrl #(
    .DDS_LATENCY (DDS_LATENCY)
  ) capture_ctrl_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .mark_o        (mark)
  );

  frame_assembler frame_assembler_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .mark_i         (mark),
    .adc_iq_i       (adc_iq_i),
    .dac_iq_i       (dac_iq_i),
    .adc_valid_i    (adc_valid_i),
    .control_word_i (control_word_i),
    .wr_o           (wr),
    .word_o         (wr_word)
  );

  sample_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) sample_fifo_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_i          (wr),
    .word_i        (wr_word),
    .pop_i         (pop),
    .word_o        (head_word),
    .empty_o       (fifo_empty),
    .overflow_o    (overflow_o)
  );

  // two cycles from write to output with ready high
  stream_out stream_out_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .word_i        (head_word),
    .empty_i       (fifo_empty),
    .pop_o         (pop),
    .m_valid_o     (m_valid_o),
    .m_data_o      (m_data_o),
    .m_last_o      (m_last_o),
    .m_ready_i     (m_ready_i)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released just after an edge, like the other stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_adc_capture.sv */
`default_nettype none

module tb_adc_capture;

  timeunit 1ns;
  timeprecision 100ps;

  import capture_pkg::*;

  localparam int unsigned DDS_LAT = DEFAULT_DDS_LATENCY;
  localparam int unsigned TEST_BUDGET [6] = '{400, 300, 900, 800, 500, 300};  // cycles

  logic        clk_245_76MHz;
  logic        cpu_reset;
  logic        adc_enable;
  logic        chirp_init;
  iq_sample_t  adc_iq;
  iq_sample_t  dac_iq;
  logic        adc_valid;
  logic [31:0] control_word;
  logic        m_valid;
  logic [63:0] m_data;
  logic        m_last;
  logic        m_ready;
  logic        overflow;

  logic [64:0] exp_q [$];  // {data, last} predicted in write order
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          ready_mode = 0;  // 0 high, 1 random, 2 low
  logic        all_valid = 1'b0;
  logic        struct_on = 1'b1;
  int          lasts_seen = 0;

  tb_clock_gen clk_gen_i (
    .clk_o (clk_245_76MHz),
    .rst_o (cpu_reset)
  );

  adc_capture_top #(
    .DDS_LATENCY (DDS_LAT),
    .FIFO_DEPTH  (DEFAULT_FIFO_DEPTH)
  ) adc_capture_top_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable),
    .chirp_init_i   (chirp_init),
    .adc_iq_i       (adc_iq),
    .dac_iq_i       (dac_iq),
    .adc_valid_i    (adc_valid),
    .control_word_i (control_word),
    .m_valid_o      (m_valid),
    .m_data_o       (m_data),
    .m_last_o       (m_last),
    .m_ready_i      (m_ready),
    .overflow_o     (overflow)
  );

  function automatic logic [31:0] route_pick(input logic [1:0] sel, input logic [31:0] adc,
                                             input logic [31:0] dac, input logic [31:0] scnt,
                                             input logic [31:0] gcnt);
    logic [31:0] v;
    v = (sel == 2'd0) ? adc : (sel == 2'd1) ? dac : (sel == 2'd2) ? scnt : gcnt;
    return v;
  endfunction

  // reference model, predicts every fifo write
  logic        m_en1, m_en2, m_first;
  int          m_hold;
  logic [31:0] m_gcnt, m_scnt;
  logic [1:0]  m_up, m_lo;

  always @(posedge clk_245_76MHz) begin : model
    logic hz, lst, mk, dw, nf;
    if (cpu_reset) begin
      m_en1   = 0;
      m_en2   = 0;
      m_first = 0;
      m_hold  = 0;
      m_gcnt  = 0;
      m_scnt  = 0;
      m_up    = 0;
      m_lo    = 0;
    end else begin
      hz  = (m_hold == 0);
      lst = hz && m_en2 && !m_en1;  // trailer on last active cycle
      mk  = m_first || lst;
      dw  = m_en2 && adc_valid && !mk;
      if (mk) exp_q.push_back({m_gcnt, m_scnt, lst});
      else if (dw) exp_q.push_back({route_pick(m_up, adc_iq, dac_iq, m_scnt, m_gcnt),
                                    route_pick(m_lo, adc_iq, dac_iq, m_scnt, m_gcnt), 1'b0});
      nf = hz && m_en1 && !m_en2;
      if (chirp_init || (m_en1 && !adc_enable)) m_hold = DDS_LAT;
      else if (!hz) m_hold = m_hold - 1;
      if (hz) m_en2 = m_en1;
      m_en1   = adc_enable;
      m_first = nf;
      m_gcnt  = m_gcnt + 1;
      if (dw) m_scnt = m_scnt + 1;
      m_up = control_word[5:4];
      m_lo = control_word[1:0];
    end
  end

  // sink side ready pattern
  always @(posedge clk_245_76MHz) begin
    #2;
    m_ready = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? 1'($urandom % 2) : 1'b0;
  end

  // output monitor, compare and frame bookkeeping
  logic        stall_q = 1'b0;
  logic [63:0] stall_data;
  logic        stall_last;
  logic        want_hdr = 1'b1;
  logic [63:0] hdr;
  logic [31:0] prev_upper = '0;
  int          n_data;

  always @(posedge clk_245_76MHz) begin : monitor
    logic [64:0] e;
    if (!cpu_reset) begin
      if (stall_q) begin
        checks++;
        assert (m_valid && m_data == stall_data && m_last == stall_last) else begin
          $display("mismatch m_valid_o/m_data_o/m_last_o under back-pressure: got %h/%h/%h expected 1/%h/%h",
                   m_valid, m_data, m_last, stall_data, stall_last);
          errors++;
        end
      end
      stall_q    = m_valid && !m_ready;
      stall_data = m_data;
      stall_last = m_last;
      if (m_valid && m_ready) begin
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("output word %h arrived with nothing expected", m_data);
          errors++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          assert ({m_data, m_last} == e) else begin
            $display("mismatch m_data_o/m_last_o: got %h/%h expected %h/%h",
                     m_data, m_last, e[64:1], e[0]);
            errors++;
          end
        end
        if (m_last) lasts_seen++;
        if (struct_on) begin
          if (want_hdr) begin
            hdr      = m_data;
            n_data   = 0;
            want_hdr = 0;
            assert (m_data[63:32] > prev_upper) else begin
              $display("mismatch m_data_o header global count: got %h previous trailer %h",
                       m_data[63:32], prev_upper);
              errors++;
            end
          end else if (m_last) begin
            assert (m_data[31:0] == hdr[31:0] + n_data && m_data[63:32] > hdr[63:32]) else begin
              $display("mismatch m_data_o trailer counts: got %h header %h words %h",
                       m_data, hdr, n_data);
              errors++;
            end
            prev_upper = m_data[63:32];
            want_hdr   = 1;
          end else begin
            n_data++;
          end
        end
      end
    end
  end

  task automatic drive_cycle(input logic en, input logic chirp);
    @(posedge clk_245_76MHz);
    #2;
    adc_enable = en;
    chirp_init = chirp;
    adc_iq     = $urandom;
    dac_iq     = $urandom;
    adc_valid  = all_valid ? 1'b1 : (($urandom % 4) != 0);
  endtask

  // wait for the output to go quiet, then the model must be used up
  task automatic drain(input logic prefix_ok);
    int quiet;
    quiet = 0;
    while (quiet < 10) begin
      @(posedge clk_245_76MHz);
      quiet = m_valid ? 0 : quiet + 1;
    end
    #2;  // back off the edge before touching stimulus
    checks++;
    if (prefix_ok) exp_q.delete();
    else assert (exp_q.size() == 0 && !overflow) else begin
      $display("%0d expected words never came out (overflow %0d)", exp_q.size(), overflow);
      errors++;
    end
  endtask

  // chirp_at counts on through the idle tail
  task automatic run_frame(input int len, input int chirp_at);
    for (int k = 0; k < len; k++) drive_cycle(1'b1, k == chirp_at);
    for (int k = len; k < len + 12; k++) drive_cycle(1'b0, k == chirp_at);  // hold-off settle
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_before) ? "ok" : "bad", errors - err_before);
  endtask

  // watchdog scaled from the test budgets
  initial begin : watchdog
    longint limit;
    limit = 0;
    foreach (TEST_BUDGET[t]) limit += TEST_BUDGET[t];
    #(limit * 4 * 20);
    $display("watchdog ran out, the run did not finish");
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    int e0;
    int l0;
    int flen;
    void'($urandom(99));
    adc_enable   = 0;
    chirp_init   = 0;
    adc_iq       = '0;
    dac_iq       = '0;
    adc_valid    = 0;
    control_word = 32'h1;
    m_ready      = 1;
    @(negedge cpu_reset);
    repeat (4) drive_cycle(1'b0, 1'b0);

    e0 = errors;  // adc upper, dac lower
    repeat (4) begin
      run_frame(8 + $urandom % 40, -1);
      drain(1'b0);
    end
    report_test("frame structure", e0);

    e0 = errors;
    all_valid = 1;
    repeat (3) begin
      run_frame(10 + $urandom % 50, -1);
      drain(1'b0);
    end
    all_valid = 0;
    report_test("counters", e0);

    e0 = errors;
    for (int c = 0; c < 16; c++) begin
      control_word      = $urandom;
      control_word[1:0] = c[1:0];
      control_word[5:4] = c[3:2];
      repeat (2) drive_cycle(1'b0, 1'b0);
      run_frame(6 + $urandom % 16, -1);
      drain(1'b0);
    end
    control_word = 32'h1;
    report_test("routing", e0);

    e0 = errors;
    ready_mode = 1;
    repeat (4) begin
      run_frame(20 + $urandom % 40, -1);
      drain(1'b0);
    end
    ready_mode = 0;
    report_test("back-pressure", e0);

    e0 = errors;
    l0 = lasts_seen;
    repeat (2) begin
      flen = 20 + $urandom % 20;
      run_frame(flen, flen + 1);  // chirp just after enable drops, inside the hold-off
      drain(1'b0);
    end
    checks++;
    assert (lasts_seen - l0 == 2) else begin
      $display("chirp frames closed with %0d trailers instead of 2", lasts_seen - l0);
      errors++;
    end
    report_test("chirp-init hold-off", e0);

    // overflow last, the flag is sticky
    e0 = errors;
    struct_on  = 0;
    ready_mode = 2;
    all_valid  = 1;
    run_frame(100, -1);
    repeat (20) drive_cycle(1'b0, 1'b0);
    checks++;
    assert (overflow) else begin
      $display("overflow flag did not rise with ready held low");
      errors++;
    end
    ready_mode = 0;
    drain(1'b1);
    checks++;
    assert (overflow) else begin
      $display("overflow flag dropped before reset");
      errors++;
    end
    report_test("overflow", e0);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
capture_pkg.sv
capture_ctrl.sv
frame_assembler.sv
sample_fifo.sv
stream_out.sv
adc_capture_top.sv
tb_clock_gen.sv
tb_adc_capture.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - capture_pkg.sv
  - capture_ctrl.sv
  - frame_assembler.sv
  - sample_fifo.sv
  - stream_out.sv
  - adc_capture_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_adc_capture.sv
